//--- common/vi_pkg.sv
// Core pipeline definitions
`default_nettype none

package vi_pkg;

	localparam int XLEN        = 32;
	localparam int ADDR_W      = 32;
	localparam int REG_ADDR_W  = 5;
	localparam int NUM_REGS    = 32;
	localparam int MULT_STAGES = 5;

	localparam logic [ADDR_W-1:0] RESET_PC = '0;

	// funct7 selectors for the OP major opcode
	localparam logic [6:0] FUNCT7_ALT    = 7'b0100000;
	localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011
	} opcode_e;

	// Operation handed from decode to execute
	typedef enum logic [2:0] {
		ALU_NONE,
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_MUL
	} alu_op_e;

	typedef enum logic {
		FETCH_IDLE,
		FETCH_WAIT
	} fetch_state_e;

endpackage

`default_nettype wire

//--- compile.f
common/vi_pkg.sv
fetch/wb_fetch.sv
decode/decoder.sv
logic/bypass_ctrl.sv
logic/int_registers.sv
execute/exe_stage.sv
execute/mult_delay.sv
logic/write_back.sv
logic/vi_core.sv
sim/tb_vi_core.sv

//--- decode/decoder.sv
// Instruction decode and issue
`timescale 1ns/1ps
`default_nettype none

module decoder (
	input  wire                           clk_i,
	input  wire                           rst_n_i,
	input  wire                           fd_valid_i,
	input  wire  [vi_pkg::XLEN-1:0]       fd_instr_i,
	input  wire                           stall_i,
	output logic [vi_pkg::REG_ADDR_W-1:0] rs1_o,
	output logic [vi_pkg::REG_ADDR_W-1:0] rs2_o,
	input  wire  [vi_pkg::XLEN-1:0]       rs1_data_i,
	input  wire  [vi_pkg::XLEN-1:0]       rs2_data_i,
	output logic                          dec_stall_o,
	output logic                          issue_valid_o,
	output vi_pkg::alu_op_e               issue_op_o,
	output logic [vi_pkg::REG_ADDR_W-1:0] issue_rd_o,
	output logic [vi_pkg::XLEN-1:0]       issue_a_o,
	output logic [vi_pkg::XLEN-1:0]       issue_b_o
);

	logic [6:0]                    funct7;
	logic [2:0]                    funct3;
	logic [vi_pkg::REG_ADDR_W-1:0] rd;
	logic [vi_pkg::XLEN-1:0]       imm;
	logic                          use_imm;
	vi_pkg::alu_op_e               op;

	assign funct7 = fd_instr_i[31:25];
	assign funct3 = fd_instr_i[14:12];
	assign rd     = fd_instr_i[11:7];
	assign rs1_o  = fd_instr_i[19:15];
	assign rs2_o  = fd_instr_i[24:20];
	assign imm    = {{(vi_pkg::XLEN-12){fd_instr_i[31]}}, fd_instr_i[31:20]};

	always_comb begin
		op      = vi_pkg::ALU_NONE;
		use_imm = 1'b0;
		case (vi_pkg::opcode_e'(fd_instr_i[6:0]))
			vi_pkg::OPC_OP: begin
				if (funct7 == 7'b0000000) begin
					case (funct3)
						3'b000:  op = vi_pkg::ALU_ADD;
						3'b100:  op = vi_pkg::ALU_XOR;
						3'b110:  op = vi_pkg::ALU_OR;
						3'b111:  op = vi_pkg::ALU_AND;
						default: op = vi_pkg::ALU_NONE;
					endcase
				end else if (funct7 == vi_pkg::FUNCT7_ALT && funct3 == 3'b000) begin
					op = vi_pkg::ALU_SUB;
				end else if (funct7 == vi_pkg::FUNCT7_MULDIV && funct3 == 3'b000) begin
					op = vi_pkg::ALU_MUL;
				end
			end
			vi_pkg::OPC_OP_IMM: begin
				if (funct3 == 3'b000) begin
					op      = vi_pkg::ALU_ADD;
					use_imm = 1'b1;
				end
			end
			default: op = vi_pkg::ALU_NONE;
		endcase
		// Results for x0 are discarded here
		if (rd == '0) begin
			op = vi_pkg::ALU_NONE;
		end
	end

	assign dec_stall_o   = fd_valid_i && stall_i;
	assign issue_valid_o = fd_valid_i && !stall_i;
	assign issue_op_o    = op;
	assign issue_rd_o    = (op == vi_pkg::ALU_NONE) ? '0 : rd;
	assign issue_a_o     = rs1_data_i;
	assign issue_b_o     = use_imm ? imm : rs2_data_i;

	// Fetch must keep a stalled word in place
	assert property (@(posedge clk_i) disable iff (!rst_n_i)
		dec_stall_o |=> fd_valid_i && $stable(fd_instr_i));

endmodule

`default_nettype wire

//--- execute/exe_stage.sv
// Execute stage with integer ALU
`timescale 1ns/1ps
`default_nettype none

module exe_stage (
	input  wire                           clk_i,
	input  wire                           rst_n_i,
	input  wire                           issue_valid_i,
	input  var   vi_pkg::alu_op_e         issue_op_i,
	input  wire  [vi_pkg::REG_ADDR_W-1:0] issue_rd_i,
	input  wire  [vi_pkg::XLEN-1:0]       issue_a_i,
	input  wire  [vi_pkg::XLEN-1:0]       issue_b_i,
	output logic                          exe_valid_o,
	output vi_pkg::alu_op_e               exe_op_o,
	output logic [vi_pkg::REG_ADDR_W-1:0] exe_rd_o,
	output logic                          alu_valid_o,
	output logic [vi_pkg::XLEN-1:0]       alu_result_o,
	output logic                          mul_valid_o,
	output logic [vi_pkg::XLEN-1:0]       mul_product_o
);

	logic [vi_pkg::XLEN-1:0] a_q;
	logic [vi_pkg::XLEN-1:0] b_q;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			exe_valid_o <= 1'b0;
		end else begin
			exe_valid_o <= issue_valid_i;
		end
	end

	always_ff @(posedge clk_i) begin
		exe_op_o <= issue_op_i;
		exe_rd_o <= issue_rd_i;
		a_q      <= issue_a_i;
		b_q      <= issue_b_i;
	end

	always_comb begin
		case (exe_op_o)
			vi_pkg::ALU_ADD: alu_result_o = a_q + b_q;
			vi_pkg::ALU_SUB: alu_result_o = a_q - b_q;
			vi_pkg::ALU_AND: alu_result_o = a_q & b_q;
			vi_pkg::ALU_OR:  alu_result_o = a_q | b_q;
			vi_pkg::ALU_XOR: alu_result_o = a_q ^ b_q;
			default:         alu_result_o = '0;
		endcase
	end

	// Low half of the product only
	assign mul_product_o = a_q * b_q;

	assign mul_valid_o = exe_valid_o && (exe_op_o == vi_pkg::ALU_MUL);
	assign alu_valid_o = exe_valid_o && (exe_op_o != vi_pkg::ALU_MUL)
		&& (exe_op_o != vi_pkg::ALU_NONE);

endmodule

`default_nettype wire

//--- execute/mult_delay.sv
// Multiply delay line
`timescale 1ns/1ps
`default_nettype none

module mult_delay (
	input  wire                           clk_i,
	input  wire                           rst_n_i,
	input  wire                           in_valid_i,
	input  wire  [vi_pkg::REG_ADDR_W-1:0] in_rd_i,
	input  wire  [vi_pkg::XLEN-1:0]       in_data_i,
	output logic                          out_valid_o,
	output logic [vi_pkg::REG_ADDR_W-1:0] out_rd_o,
	output logic [vi_pkg::XLEN-1:0]       out_data_o,
	output logic                          busy_o,
	output logic [vi_pkg::MULT_STAGES-1:0][vi_pkg::REG_ADDR_W-1:0] stage_rds_o
);

	localparam int MS = vi_pkg::MULT_STAGES;

	// Stage 0 is mult1, stage MS-1 feeds write-back
	logic [MS-1:0]                                valid_q;
	logic [MS-1:0][vi_pkg::REG_ADDR_W-1:0]        rd_q;
	logic [MS-1:0][vi_pkg::XLEN-1:0]              data_q;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			valid_q <= '0;
		end else begin
			valid_q <= {valid_q[MS-2:0], in_valid_i};
		end
	end

	always_ff @(posedge clk_i) begin
		rd_q   <= {rd_q[MS-2:0], in_rd_i};
		data_q <= {data_q[MS-2:0], in_data_i};
	end

	always_comb begin
		for (int s = 0; s < MS; s++) begin
			stage_rds_o[s] = valid_q[s] ? rd_q[s] : '0;
		end
	end

	assign busy_o      = |valid_q;
	assign out_valid_o = valid_q[MS-1];
	assign out_rd_o    = rd_q[MS-1];
	assign out_data_o  = data_q[MS-1];

endmodule

`default_nettype wire

//--- fetch/wb_fetch.sv
// Wishbone instruction fetch
`timescale 1ns/1ps
`default_nettype none

module wb_fetch (
	input  wire                       clk_i,
	input  wire                       rst_n_i,
	output logic                      wb_cyc_o,
	output logic                      wb_stb_o,
	output logic [vi_pkg::ADDR_W-1:0] wb_adr_o,
	input  wire                       wb_ack_i,
	input  wire  [vi_pkg::XLEN-1:0]   wb_dat_i,
	input  wire                       dec_stall_i,
	output logic                      fd_valid_o,
	output logic [vi_pkg::XLEN-1:0]   fd_instr_o,
	output logic [vi_pkg::ADDR_W-1:0] fd_pc_o
);

	vi_pkg::fetch_state_e      state_q;
	logic [vi_pkg::ADDR_W-1:0] pc_q;
	logic                      fd_free;
	logic                      take;

	// Slot is empty or decode takes it this cycle
	assign fd_free = !fd_valid_o || !dec_stall_i;
	assign take    = (state_q == vi_pkg::FETCH_WAIT) && wb_ack_i;

	assign wb_cyc_o = (state_q == vi_pkg::FETCH_WAIT);
	assign wb_stb_o = (state_q == vi_pkg::FETCH_WAIT);
	assign wb_adr_o = pc_q;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= vi_pkg::FETCH_IDLE;
			pc_q    <= vi_pkg::RESET_PC;
		end else begin
			case (state_q)
				vi_pkg::FETCH_IDLE: begin
					if (fd_free) begin
						state_q <= vi_pkg::FETCH_WAIT;
					end
				end
				vi_pkg::FETCH_WAIT: begin
					if (wb_ack_i) begin
						state_q <= vi_pkg::FETCH_IDLE;
						pc_q    <= pc_q + (vi_pkg::ADDR_W)'(4);
					end
				end
				default: state_q <= vi_pkg::FETCH_IDLE;
			endcase
		end
	end

	// Fetch/decode register
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			fd_valid_o <= 1'b0;
		end else if (take) begin
			fd_valid_o <= 1'b1;
		end else if (!dec_stall_i) begin
			fd_valid_o <= 1'b0;
		end
	end

	always_ff @(posedge clk_i) begin
		if (take) begin
			fd_instr_o <= wb_dat_i;
			fd_pc_o    <= pc_q;
		end
	end

	// Request held with a stable address until the slave acks
	assert property (@(posedge clk_i) disable iff (!rst_n_i)
		wb_stb_o && !wb_ack_i |=> wb_stb_o && $stable(wb_adr_o));

endmodule

`default_nettype wire

//--- logic/bypass_ctrl.sv
// Operand forwarding and hazard stall
`timescale 1ns/1ps
`default_nettype none

module bypass_ctrl (
	input  wire  [vi_pkg::REG_ADDR_W-1:0] rs1_i,
	input  wire  [vi_pkg::REG_ADDR_W-1:0] rs2_i,
	input  wire  [vi_pkg::XLEN-1:0]       reg_a_i,
	input  wire  [vi_pkg::XLEN-1:0]       reg_b_i,
	input  wire                           exe_valid_i,
	input  var   vi_pkg::alu_op_e         exe_op_i,
	input  wire  [vi_pkg::REG_ADDR_W-1:0] exe_rd_i,
	input  wire  [vi_pkg::XLEN-1:0]       exe_result_i,
	input  wire                           wb_valid_i,
	input  wire  [vi_pkg::REG_ADDR_W-1:0] wb_rd_i,
	input  wire  [vi_pkg::XLEN-1:0]       wb_data_i,
	input  wire                           mul_busy_i,
	input  wire  [vi_pkg::MULT_STAGES-1:0][vi_pkg::REG_ADDR_W-1:0] mul_rds_i,
	input  wire                           dec_is_alu_i,
	output logic                          stall_o,
	output logic [vi_pkg::XLEN-1:0]       data_a_o,
	output logic [vi_pkg::XLEN-1:0]       data_b_o
);

	logic exe_alu;
	logic exe_mul;

	assign exe_mul = exe_valid_i && (exe_op_i == vi_pkg::ALU_MUL);
	assign exe_alu = exe_valid_i && (exe_op_i != vi_pkg::ALU_MUL)
		&& (exe_op_i != vi_pkg::ALU_NONE);

	// Source still waiting on a product
	function automatic logic mul_hit(input logic [vi_pkg::REG_ADDR_W-1:0] rs);
		logic hit;
		hit = exe_mul && (exe_rd_i == rs);
		for (int s = 0; s < vi_pkg::MULT_STAGES; s++) begin
			hit = hit || (mul_rds_i[s] == rs);
		end
		return hit && (rs != '0);
	endfunction

	// youngest producer wins
	function automatic logic [vi_pkg::XLEN-1:0] pick(
		input logic [vi_pkg::REG_ADDR_W-1:0] rs,
		input logic [vi_pkg::XLEN-1:0]       reg_val
	);
		if (exe_alu && exe_rd_i == rs) begin
			return exe_result_i;
		end
		if (wb_valid_i && wb_rd_i == rs) begin
			return wb_data_i;
		end
		return reg_val;
	endfunction

	assign data_a_o = pick(rs1_i, reg_a_i);
	assign data_b_o = pick(rs2_i, reg_b_i);

	// ALU work waits until every MUL ahead of it has left the delay line
	assign stall_o = mul_hit(rs1_i) || mul_hit(rs2_i)
		|| (dec_is_alu_i && (mul_busy_i || exe_mul));

endmodule

`default_nettype wire

//--- logic/int_registers.sv
// Integer register file
`timescale 1ns/1ps
`default_nettype none

module int_registers (
	input  wire                           clk_i,
	input  wire                           rst_n_i,
	input  wire  [vi_pkg::REG_ADDR_W-1:0] rs1_i,
	input  wire  [vi_pkg::REG_ADDR_W-1:0] rs2_i,
	input  wire  [vi_pkg::REG_ADDR_W-1:0] rd_i,
	input  wire                           we_i,
	input  wire  [vi_pkg::XLEN-1:0]       wdata_i,
	output logic [vi_pkg::XLEN-1:0]       rdata_a_o,
	output logic [vi_pkg::XLEN-1:0]       rdata_b_o
);

	logic [vi_pkg::XLEN-1:0] regs_q [vi_pkg::NUM_REGS];

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < vi_pkg::NUM_REGS; i++) begin
				regs_q[i] <= '0;
			end
		end else if (we_i && rd_i != '0) begin
			regs_q[rd_i] <= wdata_i;
		end
	end

	// x0 is hardwired
	assign rdata_a_o = (rs1_i == '0) ? '0 : regs_q[rs1_i];
	assign rdata_b_o = (rs2_i == '0) ? '0 : regs_q[rs2_i];

endmodule

`default_nettype wire

//--- logic/vi_core.sv
// Pipeline top level
`timescale 1ns/1ps
`default_nettype none

module vi_core (
	input  wire                           clk_i,
	input  wire                           rst_n_i,
	output logic                          wb_cyc_o,
	output logic                          wb_stb_o,
	output logic [vi_pkg::ADDR_W-1:0]     wb_adr_o,
	input  wire                           wb_ack_i,
	input  wire  [vi_pkg::XLEN-1:0]       wb_dat_i,
	output logic                          commit_valid_o,
	output logic [vi_pkg::REG_ADDR_W-1:0] commit_rd_o,
	output logic [vi_pkg::XLEN-1:0]       commit_data_o
);

	// Fetch / decode
	logic                          fd_valid;
	logic [vi_pkg::XLEN-1:0]       fd_instr;
	logic                          dec_stall;
	logic [vi_pkg::REG_ADDR_W-1:0] rs1;
	logic [vi_pkg::REG_ADDR_W-1:0] rs2;
	logic [vi_pkg::XLEN-1:0]       rf_a;
	logic [vi_pkg::XLEN-1:0]       rf_b;
	logic [vi_pkg::XLEN-1:0]       byp_a;
	logic [vi_pkg::XLEN-1:0]       byp_b;
	logic                          byp_stall;
	logic                          dec_is_alu;

	// Issue and execute
	logic                          issue_valid;
	vi_pkg::alu_op_e               issue_op;
	logic [vi_pkg::REG_ADDR_W-1:0] issue_rd;
	logic [vi_pkg::XLEN-1:0]       issue_a;
	logic [vi_pkg::XLEN-1:0]       issue_b;
	logic                          exe_valid;
	vi_pkg::alu_op_e               exe_op;
	logic [vi_pkg::REG_ADDR_W-1:0] exe_rd;
	logic                          alu_valid;
	logic [vi_pkg::XLEN-1:0]       alu_result;
	logic                          mul_valid;
	logic [vi_pkg::XLEN-1:0]       mul_product;

	// mult1..mult5
	logic                          md_valid;
	logic [vi_pkg::REG_ADDR_W-1:0] md_rd;
	logic [vi_pkg::XLEN-1:0]       md_data;
	logic                          mul_busy;
	logic [vi_pkg::MULT_STAGES-1:0][vi_pkg::REG_ADDR_W-1:0] mul_rds;

	// Anything that is not a MUL must wait for the delay line to drain
	assign dec_is_alu = (issue_op != vi_pkg::ALU_MUL);

	wb_fetch wb_fetch (
		.clk_i		(clk_i),
		.rst_n_i	(rst_n_i),
		.wb_cyc_o	(wb_cyc_o),
		.wb_stb_o	(wb_stb_o),
		.wb_adr_o	(wb_adr_o),
		.wb_ack_i	(wb_ack_i),
		.wb_dat_i	(wb_dat_i),
		.dec_stall_i	(dec_stall),
		.fd_valid_o	(fd_valid),
		.fd_instr_o	(fd_instr),
		.fd_pc_o	()
	);

	decoder decoder (
		.clk_i		(clk_i),
		.rst_n_i	(rst_n_i),
		.fd_valid_i	(fd_valid),
		.fd_instr_i	(fd_instr),
		.stall_i	(byp_stall),
		.rs1_o		(rs1),
		.rs2_o		(rs2),
		.rs1_data_i	(byp_a),
		.rs2_data_i	(byp_b),
		.dec_stall_o	(dec_stall),
		.issue_valid_o	(issue_valid),
		.issue_op_o	(issue_op),
		.issue_rd_o	(issue_rd),
		.issue_a_o	(issue_a),
		.issue_b_o	(issue_b)
	);

	bypass_ctrl bypass_ctrl (
		.rs1_i		(rs1),
		.rs2_i		(rs2),
		.reg_a_i	(rf_a),
		.reg_b_i	(rf_b),
		.exe_valid_i	(exe_valid),
		.exe_op_i	(exe_op),
		.exe_rd_i	(exe_rd),
		.exe_result_i	(alu_result),
		.wb_valid_i	(commit_valid_o),
		.wb_rd_i	(commit_rd_o),
		.wb_data_i	(commit_data_o),
		.mul_busy_i	(mul_busy),
		.mul_rds_i	(mul_rds),
		.dec_is_alu_i	(dec_is_alu),
		.stall_o	(byp_stall),
		.data_a_o	(byp_a),
		.data_b_o	(byp_b)
	);

	int_registers int_registers (
		.clk_i		(clk_i),
		.rst_n_i	(rst_n_i),
		.rs1_i		(rs1),
		.rs2_i		(rs2),
		.rd_i		(commit_rd_o),
		.we_i		(commit_valid_o),
		.wdata_i	(commit_data_o),
		.rdata_a_o	(rf_a),
		.rdata_b_o	(rf_b)
	);

	exe_stage exe_stage (
		.clk_i		(clk_i),
		.rst_n_i	(rst_n_i),
		.issue_valid_i	(issue_valid),
		.issue_op_i	(issue_op),
		.issue_rd_i	(issue_rd),
		.issue_a_i	(issue_a),
		.issue_b_i	(issue_b),
		.exe_valid_o	(exe_valid),
		.exe_op_o	(exe_op),
		.exe_rd_o	(exe_rd),
		.alu_valid_o	(alu_valid),
		.alu_result_o	(alu_result),
		.mul_valid_o	(mul_valid),
		.mul_product_o	(mul_product)
	);

	mult_delay mult_delay (
		.clk_i		(clk_i),
		.rst_n_i	(rst_n_i),
		.in_valid_i	(mul_valid),
		.in_rd_i	(exe_rd),
		.in_data_i	(mul_product),
		.out_valid_o	(md_valid),
		.out_rd_o	(md_rd),
		.out_data_o	(md_data),
		.busy_o		(mul_busy),
		.stage_rds_o	(mul_rds)
	);

	write_back write_back (
		.clk_i		(clk_i),
		.rst_n_i	(rst_n_i),
		.alu_valid_i	(alu_valid),
		.alu_rd_i	(exe_rd),
		.alu_data_i	(alu_result),
		.mul_valid_i	(md_valid),
		.mul_rd_i	(md_rd),
		.mul_data_i	(md_data),
		.commit_valid_o	(commit_valid_o),
		.commit_rd_o	(commit_rd_o),
		.commit_data_o	(commit_data_o)
	);

endmodule

`default_nettype wire

//--- logic/write_back.sv
// Write-back and commit register
`timescale 1ns/1ps
`default_nettype none

module write_back (
	input  wire                           clk_i,
	input  wire                           rst_n_i,
	input  wire                           alu_valid_i,
	input  wire  [vi_pkg::REG_ADDR_W-1:0] alu_rd_i,
	input  wire  [vi_pkg::XLEN-1:0]       alu_data_i,
	input  wire                           mul_valid_i,
	input  wire  [vi_pkg::REG_ADDR_W-1:0] mul_rd_i,
	input  wire  [vi_pkg::XLEN-1:0]       mul_data_i,
	output logic                          commit_valid_o,
	output logic [vi_pkg::REG_ADDR_W-1:0] commit_rd_o,
	output logic [vi_pkg::XLEN-1:0]       commit_data_o
);

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			commit_valid_o <= 1'b0;
		end else begin
			commit_valid_o <= alu_valid_i || mul_valid_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (mul_valid_i) begin
			commit_rd_o   <= mul_rd_i;
			commit_data_o <= mul_data_i;
		end else begin
			commit_rd_o   <= alu_rd_i;
			commit_data_o <= alu_data_i;
		end
	end

	// Ordering stall in decode keeps the two paths apart
	assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!(alu_valid_i && mul_valid_i));

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module tb_vi_core \
	-f compile.f \
	-o tb_vi_core

./obj_dir/tb_vi_core | tee sim.log

# Pass only if the testbench printed its pass line
grep -qF '*** TEST PASSED ***' sim.log

//--- sim/tb_vi_core.sv
// Pipeline core testbench
`timescale 1ns/1ps
`default_nettype none

module tb_vi_core;

	localparam int SEED          = 58205;
	localparam int PROG_LEN      = 200;
	localparam int MAX_ACK_DELAY = 3;
	localparam int RESET_CYCLES  = 10;
	localparam int DRAIN_CYCLES  = 20;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + PROG_LEN * (MAX_ACK_DELAY + 1 + 7) + 400;
	localparam logic [31:0] NOP_WORD = 32'h00000013;

	logic        clk_i;
	logic        rst_n_i;
	logic        wb_cyc_o;
	logic        wb_stb_o;
	logic [31:0] wb_adr_o;
	logic        wb_ack_i;
	logic [31:0] wb_dat_i;
	logic        commit_valid_o;
	logic [4:0]  commit_rd_o;
	logic [31:0] commit_data_o;

	integer      seed = SEED;
	logic [31:0] prog [PROG_LEN];
	logic [31:0] model_regs [32];
	logic [36:0] exp_q [$];
	int          exp_total;
	int          commits;
	int          mismatches;
	int          failures;
	logic        in_cycle;
	logic [31:0] req_adr;
	logic [31:0] next_adr;
	int          wait_cnt;
	logic [36:0] exp_entry;

	vi_core dut (
		.clk_i          (clk_i),
		.rst_n_i        (rst_n_i),
		.wb_cyc_o       (wb_cyc_o),
		.wb_stb_o       (wb_stb_o),
		.wb_adr_o       (wb_adr_o),
		.wb_ack_i       (wb_ack_i),
		.wb_dat_i       (wb_dat_i),
		.commit_valid_o (commit_valid_o),
		.commit_rd_o    (commit_rd_o),
		.commit_data_o  (commit_data_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #10 clk_i = ~clk_i;
	end

	task automatic report_mismatch(input string test, input logic [31:0] expected,
		input logic [31:0] actual);
		mismatches++;
		$display("mismatch %s: expected %h, actual %h", test, expected, actual);
	endtask

	task automatic report_failure(input string what);
		failures++;
		$display("error: %s", what);
	endtask

	function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	// Words past the program read as ADDI x0,x0,0
	function automatic logic [31:0] fetch_word(input logic [31:0] adr);
		if ((adr >> 2) < 32'(PROG_LEN)) begin
			return prog[adr[9:2]];
		end
		return NOP_WORD;
	endfunction

	// Random program over x0..x7, executed in order on the model registers
	task automatic build_program();
		logic [31:0] r;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [11:0] imm;
		logic [31:0] res;
		logic        writes;
		int          kind;
		for (int k = 0; k < 32; k++) begin
			model_regs[k] = '0;
		end
		for (int i = 0; i < PROG_LEN; i++) begin
			r = $random(seed);
			kind = $unsigned(r) % 10;
			rd = {2'b00, r[6:4]};
			rs1 = {2'b00, r[9:7]};
			rs2 = {2'b00, r[12:10]};
			imm = r[24:13];
			writes = 1'b1;
			case (kind)
				0: begin
					prog[8'(i)] = encode_r(7'h00, 3'b000, rd, rs1, rs2);
					res = model_regs[rs1] + model_regs[rs2];
				end
				1: begin
					prog[8'(i)] = encode_r(7'h20, 3'b000, rd, rs1, rs2);
					res = model_regs[rs1] - model_regs[rs2];
				end
				2: begin
					prog[8'(i)] = encode_r(7'h00, 3'b111, rd, rs1, rs2);
					res = model_regs[rs1] & model_regs[rs2];
				end
				3: begin
					prog[8'(i)] = encode_r(7'h00, 3'b110, rd, rs1, rs2);
					res = model_regs[rs1] | model_regs[rs2];
				end
				4: begin
					prog[8'(i)] = encode_r(7'h00, 3'b100, rd, rs1, rs2);
					res = model_regs[rs1] ^ model_regs[rs2];
				end
				5: begin
					prog[8'(i)] = {imm, rs1, 3'b000, rd, 7'b0010011};
					res = model_regs[rs1] + {{20{imm[11]}}, imm};
				end
				6, 7: begin
					prog[8'(i)] = encode_r(7'h01, 3'b000, rd, rs1, rs2);
					res = model_regs[rs1] * model_regs[rs2];
				end
				8: begin
					// SLL is outside the subset
					prog[8'(i)] = encode_r(7'h00, 3'b001, rd, rs1, rs2);
					writes = 1'b0;
				end
				default: begin
					prog[8'(i)] = {r[31:12], rd, 7'b0110111};
					writes = 1'b0;
				end
			endcase
			if (writes && rd != 5'd0) begin
				model_regs[rd] = res;
				exp_q.push_back({rd, res});
			end
		end
	endtask

	// Wishbone slave with 0 to MAX_ACK_DELAY wait states
	always begin
		@(posedge clk_i);
		#1;
		if (wb_ack_i) begin
			wb_ack_i = 1'b0;
			in_cycle = 1'b0;
			assert (!wb_stb_o && !wb_cyc_o)
				else report_failure("cyc or stb still high in the cycle after ack");
		end else if (in_cycle) begin
			assert (wb_cyc_o && wb_stb_o && wb_adr_o == req_adr)
				else report_failure("request dropped or address changed before ack");
		end else if (wb_stb_o) begin
			assert (wb_cyc_o) else report_failure("stb high without cyc");
			assert (wb_adr_o == next_adr) else report_mismatch("fetch_addr", next_adr, wb_adr_o);
			req_adr = wb_adr_o;
			next_adr = next_adr + 32'd4;
			in_cycle = 1'b1;
			wait_cnt = $unsigned($random(seed)) % (MAX_ACK_DELAY + 1);
		end
		if (in_cycle) begin
			if (wait_cnt == 0) begin
				wb_ack_i = 1'b1;
				wb_dat_i = fetch_word(req_adr);
			end else begin
				wait_cnt--;
			end
		end
	end

	// Commit port against the head of the model queue
	always begin
		@(posedge clk_i);
		#1;
		if (rst_n_i && commit_valid_o) begin
			if (exp_q.size() == 0) begin
				assert (1'b0) else report_failure("commit with no write left in the model");
			end else begin
				exp_entry = exp_q.pop_front();
				assert (commit_rd_o == exp_entry[36:32])
					else report_mismatch("commit_rd", 32'(exp_entry[36:32]), 32'(commit_rd_o));
				assert (commit_data_o == exp_entry[31:0])
					else report_mismatch("commit_data", exp_entry[31:0], commit_data_o);
			end
			commits++;
		end
	end

	initial begin
		rst_n_i = 1'b0;
		wb_ack_i = 1'b0;
		wb_dat_i = '0;
		in_cycle = 1'b0;
		req_adr = '0;
		next_adr = 32'd0;
		wait_cnt = 0;
		commits = 0;
		mismatches = 0;
		failures = 0;
		build_program();
		exp_total = exp_q.size();
		repeat (RESET_CYCLES) begin
			@(posedge clk_i);
			#1;
			assert (!wb_cyc_o && !wb_stb_o && !commit_valid_o)
				else report_failure("bus or commit active during reset");
		end
		rst_n_i = 1'b1;
		// Released but no clock edge seen yet
		@(negedge clk_i);
		assert (!wb_cyc_o && !wb_stb_o && !commit_valid_o)
			else report_failure("bus or commit active right after reset");
		wait (commits == exp_total);
		// Late or extra commits would still show up here
		repeat (DRAIN_CYCLES) @(posedge clk_i);
		assert (commits == exp_total)
			else report_mismatch("commit_count", 32'(exp_total), 32'(commits));
		$display("errors: %0d mismatches, %0d other failures, %0d of %0d commits",
			mismatches, failures, commits, exp_total);
		if (mismatches == 0 && failures == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_i);
		$display("error: timeout, only %0d of %0d expected commits arrived", commits, exp_total);
		$display("errors: %0d mismatches, %0d other failures", mismatches, failures + 1);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire
